// File: verification/l2_input.txt
# src(0 ic, 1 dc, 2 both) rw addr tag0 tag1 tag2 tag3 dirty plru outcome way
# tag entry = {valid, tag[16:0]}, outcome 0 rd hit, 1 wr hit, 2 clean fill, 3 wb then fill
0 0 00919150 20200 00123 20123 20123 0 0 0 2
1 1 d5e6fff0 20001 3abcd 3abcd 00000 2 5 1 1
0 0 03bb8400 20001 20002 00777 00000 4 7 2 2
1 0 78782aa0 20011 20022 20033 20044 7 5 2 3
0 1 aaaac8d0 20100 20200 20300 20400 f 2 3 1
1 0 00008000 2abcd 21111 22222 23333 1 0 3 0
1 1 ffff8070 20005 20006 20007 20008 b 1 2 2
2 0 00211560 20042 20042 00000 20099 0 0 0 0
2 0 0007fc10 20001 20002 20003 20004 8 5 3 3
0 1 5f77b0c0 2beee 0beef 2bef0 2beef 8 3 1 3

// File: filelist.f
+incdir+hw
hw/l2_cache_pkg.sv
hw/l2_tag_match.sv
hw/l2_victim_select.sv
hw/l2_ctrl_fsm.sv
hw/l2_cache_ctrl.sv
verification/l2_cache_ctrl_props.sv
verification/l2_cache_ctrl_tb.sv

// File: Bender.yml
package:
  name: l2_cache_ctrl

export_include_dirs:
  - hw

sources:
  - files:
      - hw/l2_cache_pkg.sv
      - hw/l2_tag_match.sv
      - hw/l2_victim_select.sv
      - hw/l2_ctrl_fsm.sv
      - hw/l2_cache_ctrl.sv
  - target: test
    files:
      - verification/l2_cache_ctrl_props.sv
      - verification/l2_cache_ctrl_tb.sv

// File: verification/l2_cache_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_config.svh"

module l2_cache_ctrl_tb;

    typedef struct packed {
        logic [1:0]                                 src;      // 0 ic, 1 dc, 2 both
        logic                                       rw;
        logic [`L2_ADDR_W-1:0]                      addr;
        l2_cache_pkg::l2_tag_entry_t [`L2_WAYS-1:0] tags;
        l2_cache_pkg::l2_way_mask_t                 dirty;
        logic [2:0]                                 plru;
        logic [1:0]                                 outcome;
        l2_cache_pkg::l2_way_t                      way;
    } txn_t;

    logic                                       clk;
    logic                                       arst_n;
    logic                                       irq;
    logic                                       drq;
    logic [`L2_ADDR_W-1:0]                      addr_ic;
    logic                                       rw_ic;
    logic [`L2_ADDR_W-1:0]                      addr_dc;
    logic                                       rw_dc;
    logic                                       complete_ic;
    logic                                       complete_dc;
    logic                                       l2_complete;
    logic                                       mem_complete;
    l2_cache_pkg::l2_tag_entry_t [`L2_WAYS-1:0] tag_rd;
    l2_cache_pkg::l2_way_mask_t                 dirty_rd;
    logic [2:0]                                 plru;
    logic [`L2_INDEX_W-1:0]                     index;
    logic [`L2_OFFSET_W-1:0]                    offset;
    l2_cache_pkg::l2_way_t                      hit_way;
    l2_cache_pkg::l2_array_wr_t                 array_wr;
    l2_cache_pkg::l2_mem_req_t                  mem_req;
    l2_cache_pkg::l2_resp_t                     resp;

    txn_t   txns [$];
    int     errors = 0;
    int     cycles = 0;
    int     cycle_limit = 0;
    integer seed = 32'ha877aa93;
    logic   serving_dc = 1'b0;     // which L1 owns the current read hit

    l2_cache_ctrl dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (cycle_limit != 0 && cycles >= cycle_limit);
        $display("timeout: the run did not end within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    // arrays and memory answer each phase after a random wait
    initial begin : responder
        int dly;
        int kind;
        forever begin
            @(negedge clk);
            if (resp.l2_rdy || mem_req.mem_rw || array_wr.tag_we != '0) begin
                kind = resp.l2_rdy ? 0 : (mem_req.mem_rw ? 1 : 2);
                dly  = $unsigned($random(seed)) % 4;
                repeat (dly + 1) @(posedge clk);
                case (kind)
                    0: begin
                        if (serving_dc) complete_dc <= 1'b1;
                        else complete_ic <= 1'b1;
                    end
                    1: mem_complete <= 1'b1;
                    default: l2_complete <= 1'b1;
                endcase
                @(posedge clk);
                complete_ic  <= 1'b0;
                complete_dc  <= 1'b0;
                mem_complete <= 1'b0;
                l2_complete  <= 1'b0;
            end
        end
    end

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        errors++;
    endtask

    // hit is the lowest valid match, else first invalid way, else the plru tree
    function automatic void predict_lookup(input txn_t t, output logic [1:0] oc,
                                           output l2_cache_pkg::l2_way_t way);
        l2_cache_pkg::l2_addr_u a;
        logic found;
        int   w;
        a     = t.addr;
        found = 1'b0;
        way   = '0;
        for (w = 0; w < `L2_WAYS; w++) begin
            if (!found && t.tags[w].valid && t.tags[w].tag == a.f.tag) begin
                found = 1'b1;
                way   = l2_cache_pkg::l2_way_t'(w);
            end
        end
        if (found) begin
            oc = t.rw ? 2'd1 : 2'd0;
        end else begin
            for (w = 0; w < `L2_WAYS; w++) begin
                if (!found && !t.tags[w].valid) begin
                    found = 1'b1;
                    way   = l2_cache_pkg::l2_way_t'(w);
                end
            end
            if (!found) way = t.plru[0] ? (t.plru[2] ? 2'd3 : 2'd2) : (t.plru[1] ? 2'd1 : 2'd0);
            oc = (t.tags[way].valid && t.dirty[way]) ? 2'd3 : 2'd2;
        end
    endfunction

    // follow one accepted request from lookup back to idle
    task automatic check_response(input txn_t t, input logic [1:0] oc,
                                  input l2_cache_pkg::l2_way_t way);
        l2_cache_pkg::l2_addr_u a;
        logic [3:0]             seen;       // rdy, write hit, write-back, fill
        logic [3:0]             exp_seen;
        logic                   first;

        a     = t.addr;
        seen  = '0;
        first = 1'b1;

        @(negedge clk);
        while (!resp.l2_busy) @(negedge clk);
        while (resp.l2_busy) begin
            if (index !== a.f.index) report_mismatch("index", index, a.f.index);
            if (offset !== a.f.offset) report_mismatch("offset", offset, a.f.offset);
            if (resp.miss_stall !== oc[1]) report_mismatch("miss_stall", resp.miss_stall, oc[1]);
            if (resp.l2_rdy) begin
                seen[3] = 1'b1;
                if (hit_way !== way) report_mismatch("read hit way", hit_way, way);
                if (array_wr !== '0) report_mismatch("array_wr on read hit", array_wr, 0);
                if (mem_req !== '0) report_mismatch("mem_req on read hit", mem_req, 0);
            end
            if (array_wr.src_l1) begin
                seen[2] = 1'b1;
                if (array_wr.word_we !== 16'h1 << (way * 4 + a.f.offset))
                    report_mismatch("write hit word_we", array_wr.word_we,
                                    16'h1 << (way * 4 + a.f.offset));
                if (array_wr.tag_we !== 4'b1 << way)
                    report_mismatch("write hit tag_we", array_wr.tag_we, 4'b1 << way);
                if (array_wr.dirty_we !== 4'b1 << way)
                    report_mismatch("write hit dirty_we", array_wr.dirty_we, 4'b1 << way);
                if (array_wr.dirty_wd !== 1'b1) report_mismatch("dirty_wd", array_wr.dirty_wd, 1);
                if (array_wr.tag_wd !== {1'b1, a.f.tag})
                    report_mismatch("tag_wd", array_wr.tag_wd, {1'b1, a.f.tag});
            end
            if (mem_req.mem_rw) begin
                seen[1] = 1'b1;
                if (seen[0]) begin
                    $display("write-back started after the fill at %0t", $time);
                    errors++;
                end
                if (mem_req.mem_addr !== {t.tags[way].tag, a.f.index})
                    report_mismatch("write-back mem_addr", mem_req.mem_addr,
                                    {t.tags[way].tag, a.f.index});
                if (mem_req.wb_way !== way) report_mismatch("wb_way", mem_req.wb_way, way);
            end
            if (array_wr.src_mem) begin
                seen[0] = 1'b1;
                if (mem_req.mem_rw !== 1'b0) report_mismatch("fill mem_rw", mem_req.mem_rw, 0);
                if (mem_req.mem_addr !== a.m.block)
                    report_mismatch("fill mem_addr", mem_req.mem_addr, a.m.block);
                if (array_wr.word_we !== 16'hf << (way * 4))
                    report_mismatch("fill word_we", array_wr.word_we, 16'hf << (way * 4));
                if (array_wr.tag_we !== 4'b1 << way)
                    report_mismatch("fill tag_we", array_wr.tag_we, 4'b1 << way);
                if (array_wr.dirty_we !== 4'b1 << way)
                    report_mismatch("fill dirty_we", array_wr.dirty_we, 4'b1 << way);
                if (array_wr.tag_wd !== {1'b1, a.f.tag})
                    report_mismatch("fill tag_wd", array_wr.tag_wd, {1'b1, a.f.tag});
                if (array_wr.dirty_wd !== 1'b0)
                    report_mismatch("fill dirty_wd", array_wr.dirty_wd, 0);
                if ({resp.fill_ic, resp.fill_dc} !== {t.src != 2'd1, t.src == 2'd1})
                    report_mismatch("fill_ic/fill_dc", {resp.fill_ic, resp.fill_dc},
                                    {t.src != 2'd1, t.src == 2'd1});
            end
            @(posedge clk);
            if (first) begin
                irq <= 1'b0;
                if (t.src != 2'd2) drq <= 1'b0;    // data side keeps asking when both ask
                first = 1'b0;
            end
            @(negedge clk);
        end

        case (oc)
            2'd0: exp_seen = 4'b1000;
            2'd1: exp_seen = 4'b0100;
            2'd2: exp_seen = 4'b0001;
            default: exp_seen = 4'b0011;
        endcase
        if (seen !== exp_seen) report_mismatch("phases seen", seen, exp_seen);
    endtask

    task automatic run_txn(input txn_t t, input int num);
        txn_t                   t_dc;
        l2_cache_pkg::l2_addr_u a;
        l2_cache_pkg::l2_addr_u a_dc;
        logic [1:0]             oc;
        l2_cache_pkg::l2_way_t  way;

        a             = t.addr;
        a_dc          = t.addr;              // waiting data request in the arbitration case
        a_dc.f.index  = ~a.f.index;          // same tag in another set
        a_dc.f.offset = ~a.f.offset;
        predict_lookup(t, oc, way);
        if (oc !== t.outcome || way !== t.way) begin
            $display("input line %0d disagrees with the lookup rules", num);
            errors++;
        end

        @(posedge clk);
        tag_rd     <= t.tags;
        dirty_rd   <= t.dirty;
        plru       <= t.plru;
        addr_ic    <= a;
        rw_ic      <= t.rw;
        irq        <= (t.src != 2'd1);
        addr_dc    <= (t.src == 2'd2) ? a_dc : a;
        rw_dc      <= (t.src == 2'd2) ? 1'b0 : t.rw;
        drq        <= (t.src != 2'd0);
        serving_dc = (t.src == 2'd1);

        check_response(t, oc, way);

        // the held data request is taken at the next idle
        if (t.src == 2'd2) begin
            t_dc      = t;
            t_dc.src  = 2'd1;
            t_dc.rw   = 1'b0;
            t_dc.addr = a_dc;
            predict_lookup(t_dc, oc, way);
            serving_dc = 1'b1;
            check_response(t_dc, oc, way);
        end
    endtask

    initial begin : main
        txn_t             t;
        int               fd;
        int               n;
        int               n_txn;
        logic [31:0]      col [0:10];
        logic [8*160-1:0] line;

        arst_n       = 1'b0;
        irq          = 1'b0;
        drq          = 1'b0;
        addr_ic      = '0;
        rw_ic        = 1'b0;
        addr_dc      = '0;
        rw_dc        = 1'b0;
        complete_ic  = 1'b0;
        complete_dc  = 1'b0;
        l2_complete  = 1'b0;
        mem_complete = 1'b0;
        tag_rd       = '0;
        dirty_rd     = '0;
        plru         = '0;

        fd = $fopen("verification/l2_input.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/l2_input.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                                col[2], col[3], col[4], col[5], col[6], col[7], col[8],
                                col[9], col[10]);
                    if (n == 11) begin           // comment and blank lines drop out here
                        t.src     = col[0][1:0];
                        t.rw      = col[1][0];
                        t.addr    = col[2];
                        t.tags[0] = col[3][17:0];
                        t.tags[1] = col[4][17:0];
                        t.tags[2] = col[5][17:0];
                        t.tags[3] = col[6][17:0];
                        t.dirty   = col[7][3:0];
                        t.plru    = col[8][2:0];
                        t.outcome = col[9][1:0];
                        t.way     = col[10][1:0];
                        txns.push_back(t);
                    end
                end
            end
            $fclose(fd);
        end

        n_txn = 0;
        foreach (txns[i]) n_txn += (txns[i].src == 2'd2) ? 2 : 1;
        cycle_limit = 64 * n_txn + 10 + 8;       // reset plus a little slack

        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (array_wr !== '0) report_mismatch("array_wr after reset", array_wr, 0);
        if (mem_req !== '0) report_mismatch("mem_req after reset", mem_req, 0);
        if (resp !== '0) report_mismatch("resp after reset", resp, 0);

        foreach (txns[i]) run_txn(txns[i], i + 1);

        $display("%0d transactions run, %0d errors", txns.size(), errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/l2_cache_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module l2_cache_ctrl_props (
    input logic                       clk,
    input logic                       arst_n,
    input l2_cache_pkg::l2_state_e    state,
    input l2_cache_pkg::l2_array_wr_t array_wr,
    input l2_cache_pkg::l2_mem_req_t  mem_req,
    input l2_cache_pkg::l2_resp_t     resp
);

    // a block lands in one way only
    one_tag_we: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(array_wr.tag_we))
        else $error("tag_we set for more than one way");

    wb_only: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(mem_req.mem_rw) |-> (state == l2_cache_pkg::WRITEBACK))
        else $error("mem_rw raised outside WRITEBACK");

    idle_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        (state == l2_cache_pkg::IDLE) |-> (resp == '0))
        else $error("resp not zero in IDLE");

endmodule

bind l2_ctrl_fsm l2_cache_ctrl_props props_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .state    (state),
    .array_wr (array_wr),
    .mem_req  (mem_req),
    .resp     (resp)
);

`default_nettype wire

// File: hw/l2_cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_config.svh"

module l2_cache_ctrl (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      irq,
    input  logic                                      drq,
    input  logic [`L2_ADDR_W-1:0]                     addr_ic,
    input  logic                                      rw_ic,
    input  logic [`L2_ADDR_W-1:0]                     addr_dc,
    input  logic                                      rw_dc,
    input  logic                                      complete_ic,
    input  logic                                      complete_dc,
    input  logic                                      l2_complete,
    input  logic                                      mem_complete,
    input  l2_cache_pkg::l2_tag_entry_t [`L2_WAYS-1:0] tag_rd,
    input  l2_cache_pkg::l2_way_mask_t                dirty_rd,
    input  logic [2:0]                                plru,
    output logic [`L2_INDEX_W-1:0]                    index,
    output logic [`L2_OFFSET_W-1:0]                   offset,
    output l2_cache_pkg::l2_way_t                     hit_way,
    output l2_cache_pkg::l2_array_wr_t                array_wr,
    output l2_cache_pkg::l2_mem_req_t                 mem_req,
    output l2_cache_pkg::l2_resp_t                    resp
);

    l2_cache_pkg::l2_addr_u req_addr;
    logic                   hit;
    l2_cache_pkg::l2_way_t  victim_way;
    logic                   victim_valid;
    logic                   victim_dirty;
    logic [`L2_TAG_W-1:0]   victim_tag;

    // array address for the outside tag/data/dirty rams
    assign index  = req_addr.f.index;
    assign offset = req_addr.f.offset;

    l2_tag_match tag_match_i (
        .req_addr (req_addr),
        .tag_rd   (tag_rd),
        .hit      (hit),
        .hit_way  (hit_way)
    );

    l2_victim_select victim_select_i (
        .tag_rd       (tag_rd),
        .dirty_rd     (dirty_rd),
        .plru         (plru),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    l2_ctrl_fsm ctrl_fsm_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .irq          (irq),
        .drq          (drq),
        .addr_ic      (addr_ic),
        .rw_ic        (rw_ic),
        .addr_dc      (addr_dc),
        .rw_dc        (rw_dc),
        .complete_ic  (complete_ic),
        .complete_dc  (complete_dc),
        .l2_complete  (l2_complete),
        .mem_complete (mem_complete),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .req_addr     (req_addr),
        .array_wr     (array_wr),
        .mem_req      (mem_req),
        .resp         (resp)
    );

endmodule

`default_nettype wire

// File: hw/l2_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_config.svh"

module l2_ctrl_fsm (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        irq,
    input  logic                        drq,
    input  logic [`L2_ADDR_W-1:0]       addr_ic,
    input  logic                        rw_ic,
    input  logic [`L2_ADDR_W-1:0]       addr_dc,
    input  logic                        rw_dc,
    input  logic                        complete_ic,
    input  logic                        complete_dc,
    input  logic                        l2_complete,
    input  logic                        mem_complete,
    input  logic                        hit,
    input  l2_cache_pkg::l2_way_t       hit_way,
    input  l2_cache_pkg::l2_way_t       victim_way,
    input  logic                        victim_valid,
    input  logic                        victim_dirty,
    input  logic [`L2_TAG_W-1:0]        victim_tag,
    output l2_cache_pkg::l2_addr_u      req_addr,
    output l2_cache_pkg::l2_array_wr_t  array_wr,
    output l2_cache_pkg::l2_mem_req_t   mem_req,
    output l2_cache_pkg::l2_resp_t      resp
);

    l2_cache_pkg::l2_state_e state;
    l2_cache_pkg::l2_state_e next_state;

    logic                   req_rw;      // 1 = write from L1
    logic                   req_dc;      // request came from the data side
    l2_cache_pkg::l2_way_t  vic_way_q;
    logic [`L2_TAG_W-1:0]   vic_tag_q;
    logic                   l1_complete;

    assign l1_complete = req_dc ? complete_dc : complete_ic;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= l2_cache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // request latch, instruction side wins
    always_ff @(posedge clk) begin
        if (state == l2_cache_pkg::IDLE) begin
            if (irq) begin
                req_addr <= addr_ic;
                req_rw   <= rw_ic;
                req_dc   <= 1'b0;
            end else if (drq) begin
                req_addr <= addr_dc;
                req_rw   <= rw_dc;
                req_dc   <= 1'b1;
            end
        end
        // victim frozen at lookup, the fill may change valid bits under us
        if (state == l2_cache_pkg::ACCESS) begin
            vic_way_q <= victim_way;
            vic_tag_q <= victim_tag;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            l2_cache_pkg::IDLE: begin
                if (irq || drq) next_state = l2_cache_pkg::ACCESS;
            end
            l2_cache_pkg::ACCESS: begin
                if (hit && !req_rw) begin
                    if (l1_complete) next_state = l2_cache_pkg::IDLE;   // read hit done
                end else if (hit) begin
                    next_state = l2_cache_pkg::WRITE_HIT;
                end else if (victim_valid && victim_dirty) begin
                    next_state = l2_cache_pkg::WRITEBACK;
                end else begin
                    next_state = l2_cache_pkg::FILL;
                end
            end
            l2_cache_pkg::WRITE_HIT: begin
                if (l2_complete) next_state = l2_cache_pkg::IDLE;
            end
            l2_cache_pkg::WRITEBACK: begin
                if (mem_complete) next_state = l2_cache_pkg::FILL;
            end
            l2_cache_pkg::FILL: begin
                if (l2_complete) next_state = l2_cache_pkg::IDLE;
            end
            default: next_state = l2_cache_pkg::IDLE;
        endcase
    end

    // strobe decode, all low in idle
    always_comb begin
        array_wr = '0;
        mem_req  = '0;
        resp     = '0;

        resp.l2_busy = (state != l2_cache_pkg::IDLE);

        case (state)
            l2_cache_pkg::ACCESS: begin
                resp.l2_rdy     = hit && !req_rw;
                resp.miss_stall = !hit;
            end
            l2_cache_pkg::WRITE_HIT: begin
                array_wr.tag_we[hit_way]                      = 1'b1;
                array_wr.dirty_we[hit_way]                    = 1'b1;
                array_wr.word_we[{hit_way, req_addr.f.offset}] = 1'b1;   // single word
                array_wr.tag_wd.valid                         = 1'b1;
                array_wr.tag_wd.tag                           = req_addr.f.tag;
                array_wr.dirty_wd                             = 1'b1;
                array_wr.src_l1                               = 1'b1;
            end
            l2_cache_pkg::WRITEBACK: begin
                resp.miss_stall  = 1'b1;
                mem_req.mem_rw   = 1'b1;
                mem_req.mem_addr = {vic_tag_q, req_addr.f.index};   // old block home
                mem_req.wb_way   = vic_way_q;
            end
            l2_cache_pkg::FILL: begin
                resp.miss_stall  = 1'b1;
                resp.fill_ic     = !req_dc;
                resp.fill_dc     = req_dc;
                mem_req.mem_addr = req_addr.m.block;
                array_wr.tag_we[vic_way_q]                     = 1'b1;
                array_wr.dirty_we[vic_way_q]                   = 1'b1;
                array_wr.word_we[vic_way_q*`L2_WORDS +: `L2_WORDS] = '1;   // whole block
                array_wr.tag_wd.valid                          = 1'b1;
                array_wr.tag_wd.tag                            = req_addr.f.tag;
                array_wr.src_mem                               = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/l2_victim_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_config.svh"

module l2_victim_select (
    input  l2_cache_pkg::l2_tag_entry_t [`L2_WAYS-1:0] tag_rd,
    input  l2_cache_pkg::l2_way_mask_t                dirty_rd,
    input  logic [2:0]                                plru,
    output l2_cache_pkg::l2_way_t                     victim_way,
    output logic                                      victim_valid,
    output logic                                      victim_dirty,
    output logic [`L2_TAG_W-1:0]                      victim_tag
);

    l2_cache_pkg::l2_way_mask_t valid_vec;
    l2_cache_pkg::l2_way_t      free_way;
    l2_cache_pkg::l2_way_t      lru_way;

    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            valid_vec[w] = tag_rd[w].valid;
        end
    end

    // lowest invalid way, searched from the top down
    always_comb begin
        free_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                free_way = l2_cache_pkg::l2_way_t'(w);
            end
        end
    end

    // tree plru, bit 0 picks the half and bit 1 or 2 the way inside it
    always_comb begin
        if (plru[0]) begin
            lru_way = plru[2] ? 2'd3 : 2'd2;
        end else begin
            lru_way = plru[1] ? 2'd1 : 2'd0;
        end
    end

    assign victim_way   = (&valid_vec) ? lru_way : free_way;
    assign victim_valid = tag_rd[victim_way].valid;
    assign victim_dirty = dirty_rd[victim_way];
    assign victim_tag   = tag_rd[victim_way].tag;   // feeds the write-back address

endmodule

`default_nettype wire

// File: hw/l2_tag_match.sv
`timescale 1ns/1ps
`default_nettype none

`include "l2_cache_config.svh"

module l2_tag_match (
    input  l2_cache_pkg::l2_addr_u                    req_addr,
    input  l2_cache_pkg::l2_tag_entry_t [`L2_WAYS-1:0] tag_rd,
    output logic                                      hit,
    output l2_cache_pkg::l2_way_t                     hit_way
);

    l2_cache_pkg::l2_way_mask_t match;

    // per-way compare, only valid entries count
    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            match[w] = tag_rd[w].valid && (tag_rd[w].tag == req_addr.f.tag);
        end
    end

    // walk downwards so the lowest matching way is left standing
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit     = 1'b1;
                hit_way = l2_cache_pkg::l2_way_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/l2_cache_pkg.sv
`default_nettype none

`include "l2_cache_config.svh"

package l2_cache_pkg;

    // cache view of a request address
    typedef struct packed {
        logic [`L2_TAG_W-1:0]    tag;
        logic [`L2_INDEX_W-1:0]  index;
        logic [`L2_OFFSET_W-1:0] offset;
        logic [`L2_BYTE_W-1:0]   byte_off;
    } l2_addr_fields_t;

    // memory view, block number plus byte in block
    typedef struct packed {
        logic [`L2_BLOCK_W-1:0]              block;
        logic [`L2_OFFSET_W+`L2_BYTE_W-1:0]  blk_byte;
    } l2_mem_addr_t;

    typedef union packed {
        l2_addr_fields_t f;
        l2_mem_addr_t    m;
    } l2_addr_u;

    // one entry of the tag array
    typedef struct packed {
        logic                 valid;
        logic [`L2_TAG_W-1:0] tag;
    } l2_tag_entry_t;

    typedef logic [$clog2(`L2_WAYS)-1:0] l2_way_t;
    typedef logic [`L2_WAYS-1:0]         l2_way_mask_t;

    typedef struct packed {
        l2_way_mask_t                  tag_we;
        l2_way_mask_t                  dirty_we;
        logic [`L2_WAYS*`L2_WORDS-1:0] word_we;   // way-major, {way, word}
        l2_tag_entry_t                 tag_wd;
        logic                          dirty_wd;
        logic                          src_l1;    // data from the L1 write
        logic                          src_mem;   // data from the memory read
    } l2_array_wr_t;

    typedef struct packed {
        logic                   mem_rw;   // 1 = write back
        logic [`L2_BLOCK_W-1:0] mem_addr;
        l2_way_t                wb_way;
    } l2_mem_req_t;

    typedef struct packed {
        logic l2_rdy;
        logic l2_busy;
        logic miss_stall;
        logic fill_ic;
        logic fill_dc;
    } l2_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        ACCESS,
        WRITE_HIT,
        WRITEBACK,
        FILL
    } l2_state_e;

endpackage

`default_nettype wire

// File: hw/l2_cache_config.svh
`ifndef L2_CACHE_CONFIG_SVH
`define L2_CACHE_CONFIG_SVH

// set geometry
`define L2_WAYS      4
`define L2_WORDS     4          // 128-bit words per block

// address split, tag | index | offset | byte
`define L2_ADDR_W    32
`define L2_TAG_W     17
`define L2_INDEX_W   9
`define L2_OFFSET_W  2
`define L2_BYTE_W    4

// memory side sees whole 64-byte blocks
`define L2_BLOCK_W   26

`endif
